// File: hw/eth_regs_pkg.sv
// ======================================
// Ethernet MAC host register map
// Word address views and host request types
// ======================================
package eth_regs_pkg;

  // Register indices within the CSR region
  localparam logic [4:0] REG_SCRATCH0  = 5'd0;
  localparam logic [4:0] REG_SCRATCH1  = 5'd1;
  localparam logic [4:0] REG_SCRATCH2  = 5'd2;
  localparam logic [4:0] REG_SCRATCH3  = 5'd3;
  localparam logic [4:0] REG_TX_LEN0   = 5'd8;
  localparam logic [4:0] REG_TX_STAT0  = 5'd9;
  localparam logic [4:0] REG_TX_LEN1   = 5'd10;
  localparam logic [4:0] REG_TX_STAT1  = 5'd11;
  localparam logic [4:0] REG_INTR_EN   = 5'd14;
  localparam logic [4:0] REG_INTR_STAT = 5'd15;

  // Top two bits of the word address
  localparam logic [1:0] REGION_CSR   = 2'd0;
  localparam logic [1:0] REGION_TXRAM = 2'd1;

  typedef struct packed {
    logic [1:0] region;
    logic [4:0] unused;
    logic [4:0] index;
  } csr_addr_t;

  typedef struct packed {
    logic [1:0] region;
    logic [9:0] word;
  } ram_addr_t;

  // Same 12-bit word address, seen as a register or a RAM word
  typedef union packed {
    csr_addr_t csr;
    ram_addr_t ram;
  } word_addr_u;

  typedef struct packed {
    logic        rd;
    logic        wr;
    word_addr_u  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        rd_done;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

// File: hw/eth_tx_pkg.sv
// ======================================
// Transmit side types
// Engine control, events and RAM ports
// ======================================
package eth_tx_pkg;

  typedef struct packed {
    logic [1:0]  go;
    logic [10:0] len0;
    logic [10:0] len1;
  } tx_ctrl_t;

  typedef struct packed {
    logic done;
    logic buf_sel;
  } tx_evt_t;

  typedef struct packed {
    logic        en;
    logic [9:0]  addr;
    logic [31:0] data;
  } ram_wr_t;

  typedef struct packed {
    logic       en;
    logic [9:0] addr;
  } ram_rd_t;

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    DONE,
    IFG
  } tx_state_e;

endpackage

// File: hw/axil_slave.sv
// ======================================
// AXI4-Lite slave
// Turns bus transfers into single-cycle
// register requests
// ======================================
`timescale 1ns/1ps

module axil_slave (
  input  logic                    s_axi_aclk,
  input  logic                    s_axi_aresetn,
  input  logic [13:0]             s_axi_awaddr_i,
  input  logic                    s_axi_awvalid_i,
  output logic                    s_axi_awready_o,
  input  logic [31:0]             s_axi_wdata_i,
  input  logic [3:0]              s_axi_wstrb_i,
  input  logic                    s_axi_wvalid_i,
  output logic                    s_axi_wready_o,
  output logic [1:0]              s_axi_bresp_o,
  output logic                    s_axi_bvalid_o,
  input  logic                    s_axi_bready_i,
  input  logic [13:0]             s_axi_araddr_i,
  input  logic                    s_axi_arvalid_i,
  output logic                    s_axi_arready_o,
  output logic [31:0]             s_axi_rdata_o,
  output logic [1:0]              s_axi_rresp_o,
  output logic                    s_axi_rvalid_o,
  input  logic                    s_axi_rready_i,
  output eth_regs_pkg::reg_req_t  req_o,
  input  eth_regs_pkg::reg_rsp_t  rsp_i
);
  import eth_regs_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_REQ, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_RESP} rd_state_e;

  wr_state_e   wr_state_q;
  rd_state_e   rd_state_q;
  word_addr_u  waddr_q;
  word_addr_u  raddr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  logic        wr_issue;
  logic        rd_issue;

  assign s_axi_awready_o = (wr_state_q == WR_IDLE);
  assign s_axi_wready_o  = (wr_state_q == WR_IDLE) || (wr_state_q == WR_DATA);
  assign s_axi_arready_o = (rd_state_q == RD_IDLE);
  assign s_axi_bresp_o   = 2'b00;
  assign s_axi_rresp_o   = 2'b00;

  // Write wins when both sides want the request port
  assign wr_issue = (wr_state_q == WR_REQ);
  assign rd_issue = (rd_state_q == RD_REQ) && !wr_issue;

  // ======================================
  // Write channel
  // ======================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state_q     <= WR_IDLE;
      s_axi_bvalid_o <= 1'b0;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (s_axi_awvalid_i) begin
            wr_state_q <= s_axi_wvalid_i ? WR_REQ : WR_DATA;
          end
        end
        WR_DATA: begin
          if (s_axi_wvalid_i) begin
            wr_state_q <= WR_REQ;
          end
        end
        WR_REQ: wr_state_q <= WR_RESP;
        WR_RESP: begin
          if (!s_axi_bvalid_o) begin
            s_axi_bvalid_o <= 1'b1;
          end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
            wr_state_q     <= WR_IDLE;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // ======================================
  // Read channel
  // ======================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state_q     <= RD_IDLE;
      s_axi_rvalid_o <= 1'b0;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (s_axi_arvalid_i) begin
            rd_state_q <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (rd_issue) begin
            rd_state_q <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (rsp_i.rd_done) begin
            s_axi_rvalid_o <= 1'b1;
          end else if (s_axi_rvalid_o && s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
            rd_state_q     <= RD_IDLE;
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // Address, data and read data capture
  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_awready_o && s_axi_awvalid_i) begin
      waddr_q <= s_axi_awaddr_i[13:2];
    end
    if (s_axi_wvalid_i &&
        ((wr_state_q == WR_DATA) || (wr_state_q == WR_IDLE && s_axi_awvalid_i))) begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    if (s_axi_arready_o && s_axi_arvalid_i) begin
      raddr_q <= s_axi_araddr_i[13:2];
    end
    if ((rd_state_q == RD_RESP) && rsp_i.rd_done) begin
      s_axi_rdata_o <= rsp_i.rdata;
    end
  end

  // Registered request, one cycle per transfer
  // A write with no strobes set changes nothing
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      req_o <= '0;
    end else begin
      req_o.wr    <= wr_issue && (wstrb_q != 4'h0);
      req_o.rd    <= rd_issue;
      req_o.addr  <= wr_issue ? waddr_q : raddr_q;
      req_o.wdata <= wdata_q;
    end
  end

endmodule

// File: hw/mac_csr.sv
// ======================================
// MAC register bank
// Scratch, transmit control, interrupt
// state and host access to the frame RAM
// ======================================
`timescale 1ns/1ps

module mac_csr #(
  parameter int DATA_W = 32
) (
  input  logic                    s_axi_aclk,
  input  logic                    s_axi_aresetn,
  input  eth_regs_pkg::reg_req_t  req_i,
  output eth_regs_pkg::reg_rsp_t  rsp_o,
  output eth_tx_pkg::ram_wr_t     ram_wr_o,
  output eth_tx_pkg::ram_rd_t     ram_rd_o,
  input  logic [DATA_W-1:0]       ram_rdata_i,
  output eth_tx_pkg::tx_ctrl_t    tx_ctrl_o,
  input  eth_tx_pkg::tx_evt_t     tx_evt_i,
  output logic                    eth_irq_o
);
  import eth_regs_pkg::*;
  import eth_tx_pkg::*;

  logic [4:0]  idx;
  logic        csr_hit;
  logic        ram_hit;
  logic        wr_csr;
  logic [1:0]  go_set;
  logic [1:0]  go_clr;
  logic [31:0] scratch_q [4];
  tx_ctrl_t    ctrl_q;
  logic        intr_en_q;
  logic        intr_stat_q;
  logic [31:0] csr_rdata;
  logic [31:0] rd_csr_q;
  logic        rd_done_q;
  logic        rd_ram_q;

  // ======================================
  // Address decode
  // ======================================
  assign idx     = req_i.addr.csr.index;
  assign csr_hit = (req_i.addr.csr.region == REGION_CSR) && (req_i.addr.csr.unused == '0);
  assign ram_hit = (req_i.addr.ram.region == REGION_TXRAM);
  assign wr_csr  = req_i.wr && csr_hit;

  assign ram_wr_o.en   = req_i.wr && ram_hit;
  assign ram_wr_o.addr = req_i.addr.ram.word;
  assign ram_wr_o.data = req_i.wdata;
  assign ram_rd_o.en   = req_i.rd && ram_hit;
  assign ram_rd_o.addr = req_i.addr.ram.word;

  // Host sets go, the engine clears it at end of frame
  assign go_set[0] = wr_csr && (idx == REG_TX_STAT0) && req_i.wdata[0];
  assign go_set[1] = wr_csr && (idx == REG_TX_STAT1) && req_i.wdata[0];
  assign go_clr    = {2{tx_evt_i.done}} & {tx_evt_i.buf_sel, !tx_evt_i.buf_sel};

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      for (int i = 0; i < 4; i++) begin
        scratch_q[i] <= '0;
      end
      ctrl_q      <= '0;
      intr_en_q   <= 1'b0;
      intr_stat_q <= 1'b0;
      rd_done_q   <= 1'b0;
      rd_ram_q    <= 1'b0;
    end else begin
      if (wr_csr) begin
        case (idx)
          REG_SCRATCH0: scratch_q[0] <= req_i.wdata;
          REG_SCRATCH1: scratch_q[1] <= req_i.wdata;
          REG_SCRATCH2: scratch_q[2] <= req_i.wdata;
          REG_SCRATCH3: scratch_q[3] <= req_i.wdata;
          REG_TX_LEN0:  ctrl_q.len0  <= req_i.wdata[10:0];
          REG_TX_LEN1:  ctrl_q.len1  <= req_i.wdata[10:0];
          REG_INTR_EN:  intr_en_q    <= req_i.wdata[0];
          default: ;
        endcase
      end

      ctrl_q.go <= (ctrl_q.go & ~go_clr) | go_set;

      // Write 1 to clear
      if (wr_csr && (idx == REG_INTR_STAT) && req_i.wdata[0]) begin
        intr_stat_q <= 1'b0;
      end else if (tx_evt_i.done) begin
        intr_stat_q <= 1'b1;
      end

      rd_done_q <= req_i.rd;
      rd_ram_q  <= req_i.rd && ram_hit;
    end
  end

  // ======================================
  // Read data
  // ======================================
  always_comb begin
    csr_rdata = '0;
    if (csr_hit) begin
      case (idx)
        REG_SCRATCH0:  csr_rdata = scratch_q[0];
        REG_SCRATCH1:  csr_rdata = scratch_q[1];
        REG_SCRATCH2:  csr_rdata = scratch_q[2];
        REG_SCRATCH3:  csr_rdata = scratch_q[3];
        REG_TX_LEN0:   csr_rdata = {21'b0, ctrl_q.len0};
        REG_TX_STAT0:  csr_rdata = {31'b0, ctrl_q.go[0]};
        REG_TX_LEN1:   csr_rdata = {21'b0, ctrl_q.len1};
        REG_TX_STAT1:  csr_rdata = {31'b0, ctrl_q.go[1]};
        REG_INTR_EN:   csr_rdata = {31'b0, intr_en_q};
        REG_INTR_STAT: csr_rdata = {31'b0, intr_stat_q};
        default:       csr_rdata = '0;
      endcase
    end
  end

  // Register value held so it lines up with the RAM read
  always_ff @(posedge s_axi_aclk) begin
    if (req_i.rd) begin
      rd_csr_q <= csr_rdata;
    end
  end

  assign rsp_o.rd_done = rd_done_q;
  assign rsp_o.rdata   = rd_ram_q ? ram_rdata_i : rd_csr_q;

  assign tx_ctrl_o = ctrl_q;
  assign eth_irq_o = intr_en_q & intr_stat_q;

endmodule

// File: hw/tx_frame_ram.sv
// ======================================
// Transmit frame buffer
// Host read/write port, engine read port
// ======================================
`timescale 1ns/1ps

module tx_frame_ram #(
  parameter int DATA_W    = 32,
  parameter int RAM_DEPTH = 1024
) (
  input  logic                 s_axi_aclk,
  input  eth_tx_pkg::ram_wr_t  host_wr_i,
  input  eth_tx_pkg::ram_rd_t  host_rd_i,
  output logic [DATA_W-1:0]    host_rdata_o,
  input  eth_tx_pkg::ram_rd_t  eng_rd_i,
  output logic [DATA_W-1:0]    eng_rdata_o
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge s_axi_aclk) begin
    if (host_wr_i.en) begin
      mem[host_wr_i.addr] <= host_wr_i.data;
    end
    if (host_rd_i.en) begin
      host_rdata_o <= mem[host_rd_i.addr];
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (eng_rd_i.en) begin
      eng_rdata_o <= mem[eng_rd_i.addr];
    end
  end

endmodule

// File: hw/tx_engine.sv
// ======================================
// Transmit engine
// Streams a buffer as MII nibbles, then
// holds the inter-frame gap
// ======================================
`timescale 1ns/1ps

module tx_engine #(
  parameter int TX_IFG_CYCLES = 24
) (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  input  eth_tx_pkg::tx_ctrl_t  tx_ctrl_i,
  output eth_tx_pkg::tx_evt_t   tx_evt_o,
  output eth_tx_pkg::ram_rd_t   ram_rd_o,
  input  logic [31:0]           ram_rdata_i,
  input  logic                  phy_crs_i,
  output logic                  phy_tx_en_o,
  output logic [3:0]            phy_tx_data_o
);
  import eth_tx_pkg::*;

  localparam int IFG_W = $clog2(TX_IFG_CYCLES + 1);

  tx_state_e        state_q;
  tx_state_e        state_d;
  logic             cur_buf_q;
  logic [11:0]      nib_cnt_q;
  logic [11:0]      nib_last;
  logic [2:0]       nib_lsb_q;
  logic             nib_vld_q;
  logic [IFG_W-1:0] ifg_cnt_q;

  // Two nibbles per byte
  assign nib_last = (cur_buf_q ? {tx_ctrl_i.len1, 1'b0} : {tx_ctrl_i.len0, 1'b0}) - 12'd1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if ((|tx_ctrl_i.go) && !phy_crs_i) begin
          state_d = DATA;
        end
      end
      DATA: begin
        if (nib_cnt_q == nib_last) begin
          state_d = DONE;
        end
      end
      DONE: state_d = IFG;
      IFG: begin
        if (ifg_cnt_q == IFG_W'(TX_IFG_CYCLES - 1)) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      state_q   <= IDLE;
      cur_buf_q <= 1'b0;
      nib_cnt_q <= '0;
      nib_lsb_q <= '0;
      nib_vld_q <= 1'b0;
      ifg_cnt_q <= '0;
    end else begin
      state_q <= state_d;

      // Buffer 0 goes first when both are armed
      if (state_q == IDLE) begin
        cur_buf_q <= !tx_ctrl_i.go[0];
      end

      if (state_q == DATA) begin
        nib_cnt_q <= nib_cnt_q + 12'd1;
      end else begin
        nib_cnt_q <= '0;
      end

      // Follows the word read by one cycle
      nib_lsb_q <= nib_cnt_q[2:0];
      nib_vld_q <= (state_q == DATA);

      if (state_q == IFG) begin
        ifg_cnt_q <= ifg_cnt_q + 1'b1;
      end else begin
        ifg_cnt_q <= '0;
      end
    end
  end

  // ======================================
  // RAM read and MII output
  // ======================================
  assign ram_rd_o.en   = (state_q == DATA);
  assign ram_rd_o.addr = {cur_buf_q, nib_cnt_q[11:3]};

  // Low nibble of each word first
  assign phy_tx_en_o   = nib_vld_q;
  assign phy_tx_data_o = nib_vld_q ? ram_rdata_i[{nib_lsb_q, 2'b00} +: 4] : 4'h0;

  assign tx_evt_o.done    = (state_q == DONE);
  assign tx_evt_o.buf_sel = cur_buf_q;

endmodule

// File: hw/eth_mac_tx.sv
// ======================================
// Ethernet MAC transmit top level
// AXI4-Lite host port to MII transmit
// ======================================
`timescale 1ns/1ps

module eth_mac_tx #(
  parameter int DATA_W        = 32,
  parameter int RAM_DEPTH     = 1024,
  parameter int TX_IFG_CYCLES = 24
) (
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  input  logic [13:0] s_axi_awaddr_i,
  input  logic        s_axi_awvalid_i,
  output logic        s_axi_awready_o,
  input  logic [31:0] s_axi_wdata_i,
  input  logic [3:0]  s_axi_wstrb_i,
  input  logic        s_axi_wvalid_i,
  output logic        s_axi_wready_o,
  output logic [1:0]  s_axi_bresp_o,
  output logic        s_axi_bvalid_o,
  input  logic        s_axi_bready_i,
  input  logic [13:0] s_axi_araddr_i,
  input  logic        s_axi_arvalid_i,
  output logic        s_axi_arready_o,
  output logic [31:0] s_axi_rdata_o,
  output logic [1:0]  s_axi_rresp_o,
  output logic        s_axi_rvalid_o,
  input  logic        s_axi_rready_i,
  input  logic        phy_crs_i,
  output logic        phy_tx_en_o,
  output logic [3:0]  phy_tx_data_o,
  output logic        eth_irq_o
);
  import eth_regs_pkg::*;
  import eth_tx_pkg::*;

  reg_req_t          req;
  reg_rsp_t          rsp;
  ram_wr_t           host_wr;
  ram_rd_t           host_rd;
  ram_rd_t           eng_rd;
  logic [DATA_W-1:0] host_rdata;
  logic [DATA_W-1:0] eng_rdata;
  tx_ctrl_t          tx_ctrl;
  tx_evt_t           tx_evt;

  axil_slave u_axil_slave (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .req_o           (req),
    .rsp_i           (rsp)
  );

  mac_csr #(
    .DATA_W (DATA_W)
  ) u_mac_csr (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .req_i         (req),
    .rsp_o         (rsp),
    .ram_wr_o      (host_wr),
    .ram_rd_o      (host_rd),
    .ram_rdata_i   (host_rdata),
    .tx_ctrl_o     (tx_ctrl),
    .tx_evt_i      (tx_evt),
    .eth_irq_o     (eth_irq_o)
  );

  tx_frame_ram #(
    .DATA_W    (DATA_W),
    .RAM_DEPTH (RAM_DEPTH)
  ) u_tx_frame_ram (
    .s_axi_aclk   (s_axi_aclk),
    .host_wr_i    (host_wr),
    .host_rd_i    (host_rd),
    .host_rdata_o (host_rdata),
    .eng_rd_i     (eng_rd),
    .eng_rdata_o  (eng_rdata)
  );

  tx_engine #(
    .TX_IFG_CYCLES (TX_IFG_CYCLES)
  ) u_tx_engine (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .tx_ctrl_i     (tx_ctrl),
    .tx_evt_o      (tx_evt),
    .ram_rd_o      (eng_rd),
    .ram_rdata_i   (eng_rdata),
    .phy_crs_i     (phy_crs_i),
    .phy_tx_en_o   (phy_tx_en_o),
    .phy_tx_data_o (phy_tx_data_o)
  );

endmodule

// File: bench/tb_eth_mac_tx.sv
// ======================================
// Testbench for the MAC transmit top
// Random register, RAM and frame traffic
// checked against a local model
// ======================================
`timescale 1ns/1ps

module tb_eth_mac_tx;
  import eth_regs_pkg::*;

  localparam int IFG_CYCLES     = 24;
  localparam int TIMEOUT_CYCLES = 200000;
  localparam int POLL_LIMIT     = 400;

  logic        s_axi_aclk;
  logic        s_axi_aresetn;
  logic [13:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [13:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        phy_crs;
  logic        phy_tx_en;
  logic [3:0]  phy_tx_data;
  logic        eth_irq;

  // Model state
  logic [31:0] ram_model [1024];
  logic [31:0] scratch_model [4];
  logic [3:0]  exp_q [$];
  logic [3:0]  got_q [$];

  int cycles       = 0;
  int checks       = 0;
  int errors       = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int low_run      = 0;
  int min_gap      = 0;
  int starts       = 0;
  logic en_prev    = 1'b0;

  eth_mac_tx #(
    .DATA_W        (32),
    .RAM_DEPTH     (1024),
    .TX_IFG_CYCLES (IFG_CYCLES)
  ) uut (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .phy_crs_i       (phy_crs),
    .phy_tx_en_o     (phy_tx_en),
    .phy_tx_data_o   (phy_tx_data),
    .eth_irq_o       (eth_irq)
  );

  always #20 s_axi_aclk = ~s_axi_aclk;

  always @(posedge s_axi_aclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ======================================
  // MII monitor
  // ======================================
  always @(negedge s_axi_aclk) begin
    if (phy_tx_en === 1'b1) begin
      if (!en_prev) begin
        if (starts > 0 && low_run < min_gap) begin
          min_gap = low_run;
        end
        starts++;
      end
      got_q.push_back(phy_tx_data);
      low_run = 0;
    end else begin
      low_run++;
    end
    en_prev = (phy_tx_en === 1'b1);
  end

  function automatic logic [13:0] csr_byte_addr(input logic [4:0] idx);
    word_addr_u wa;
    wa = '0;
    wa.csr.region = REGION_CSR;
    wa.csr.index  = idx;
    return {wa, 2'b00};
  endfunction

  function automatic logic [13:0] ram_byte_addr(input logic [9:0] word);
    word_addr_u wa;
    wa = '0;
    wa.ram.region = REGION_TXRAM;
    wa.ram.word   = word;
    return {wa, 2'b00};
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", what, got, exp);
      test_errors++;
    end
  endtask

  task automatic write_bus(input logic [13:0] addr, input logic [31:0] data);
    @(negedge s_axi_aclk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    while (!(awready && wready)) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    while (!bvalid) @(negedge s_axi_aclk);
    expect_equal("s_axi_bresp_o", 32'(bresp), 32'h0);
    @(negedge s_axi_aclk);
    bready = 1'b0;
  endtask

  task automatic read_bus(input logic [13:0] addr, output logic [31:0] data);
    @(negedge s_axi_aclk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) @(negedge s_axi_aclk);
    data = rdata;
    expect_equal("s_axi_rresp_o", 32'(rresp), 32'h0);
    @(negedge s_axi_aclk);
    rready = 1'b0;
  endtask

  task automatic read_expect(input string what, input logic [13:0] addr,
                             input logic [31:0] exp);
    logic [31:0] v;
    read_bus(addr, v);
    expect_equal(what, v, exp);
  endtask

  // Fills a buffer with random words, sets its length and queues the nibbles
  task automatic load_frame(input logic buf_sel, input int len);
    int          base;
    logic [31:0] w;
    base = buf_sel ? 512 : 0;
    for (int i = 0; i < (len + 3) / 4; i++) begin
      w = $urandom;
      write_bus(ram_byte_addr(10'(base + i)), w);
      ram_model[base + i] = w;
    end
    write_bus(csr_byte_addr(buf_sel ? REG_TX_LEN1 : REG_TX_LEN0), 32'(len));
    // Eight nibbles per word, low nibble first
    for (int k = 0; k < 2 * len; k++) begin
      exp_q.push_back(ram_model[base + k / 8][4 * (k % 8) +: 4]);
    end
  endtask

  task automatic wait_go_clear(input logic [4:0] idx);
    logic [31:0] v;
    int          tries;
    v     = 32'h1;
    tries = 0;
    while (v[0] && tries < POLL_LIMIT) begin
      read_bus(csr_byte_addr(idx), v);
      tries++;
    end
    checks++;
    assert (!v[0]) else begin
      $display("ERROR: go bit in register %0d still set after %0d polls", idx, tries);
      test_errors++;
    end
  endtask

  task automatic compare_frame(input string name);
    int n;
    logic ok;
    expect_equal({name, " phy_tx_en_o cycles"}, 32'(got_q.size()), 32'(exp_q.size()));
    n  = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    ok = 1'b1;
    for (int i = 0; i < n && ok; i++) begin
      checks++;
      assert (got_q[i] === exp_q[i]) else begin
        $display("FAIL phy_tx_data_o %s nibble %0d: got 0x%h, expected 0x%h",
                 name, i, got_q[i], exp_q[i]);
        test_errors++;
        ok = 1'b0;
      end
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  // ======================================
  // Test sequence
  // ======================================
  initial begin
    int          len0;
    int          len1;
    int          hold;
    int          highs;
    logic [4:0]  idx;
    logic [9:0]  word;
    logic [31:0] v;
    logic [9:0]  addr_q [$];

    void'($urandom(32'h88c75e1d));
    s_axi_aclk    = 1'b0;
    s_axi_aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    phy_crs = 1'b0;
    repeat (10) @(negedge s_axi_aclk);
    s_axi_aresetn = 1'b1;
    @(negedge s_axi_aclk);

    expect_equal("s_axi_awready_o", 32'(awready), 32'h1);
    expect_equal("s_axi_wready_o", 32'(wready), 32'h1);
    expect_equal("s_axi_arready_o", 32'(arready), 32'h1);
    expect_equal("s_axi_bvalid_o", 32'(bvalid), 32'h0);
    expect_equal("s_axi_rvalid_o", 32'(rvalid), 32'h0);
    expect_equal("phy_tx_en_o", 32'(phy_tx_en), 32'h0);
    expect_equal("eth_irq_o", 32'(eth_irq), 32'h0);
    end_test("reset state");

    for (int i = 0; i < 4; i++) begin
      scratch_model[i] = $urandom;
      write_bus(csr_byte_addr(REG_SCRATCH0 + 5'(i)), scratch_model[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_expect($sformatf("s_axi_rdata_o scratch%0d", i),
                  csr_byte_addr(REG_SCRATCH0 + 5'(i)), scratch_model[i]);
    end
    for (int i = 0; i < 8; i++) begin
      do begin
        idx = 5'($urandom);
      end while (idx inside {REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3,
                             REG_TX_LEN0, REG_TX_STAT0, REG_TX_LEN1, REG_TX_STAT1,
                             REG_INTR_EN, REG_INTR_STAT});
      read_expect($sformatf("s_axi_rdata_o unmapped %0d", idx), csr_byte_addr(idx), 32'h0);
    end
    end_test("scratch registers");

    for (int i = 0; i < 16; i++) begin
      word = 10'($urandom);
      v    = $urandom;
      write_bus(ram_byte_addr(word), v);
      ram_model[word] = v;
      addr_q.push_back(word);
    end
    foreach (addr_q[i]) begin
      read_expect($sformatf("s_axi_rdata_o ram[0x%03h]", addr_q[i]),
                  ram_byte_addr(addr_q[i]), ram_model[addr_q[i]]);
    end
    end_test("frame ram access");

    len0 = $urandom_range(64, 1);
    load_frame(1'b0, len0);
    got_q.delete();
    write_bus(csr_byte_addr(REG_TX_STAT0), 32'h1);
    wait_go_clear(REG_TX_STAT0);
    compare_frame("buf0");
    read_expect("s_axi_rdata_o TX_STAT0", csr_byte_addr(REG_TX_STAT0), 32'h0);
    end_test("single frame");

    len0 = $urandom_range(64, 1);
    len1 = $urandom_range(64, 1);
    load_frame(1'b0, len0);
    load_frame(1'b1, len1);
    got_q.delete();
    starts  = 0;
    min_gap = 1 << 30;
    // Carrier holds the engine in IDLE until both buffers are pending
    phy_crs = 1'b1;
    write_bus(csr_byte_addr(REG_TX_STAT1), 32'h1);
    write_bus(csr_byte_addr(REG_TX_STAT0), 32'h1);
    phy_crs = 1'b0;
    wait_go_clear(REG_TX_STAT0);
    wait_go_clear(REG_TX_STAT1);
    compare_frame("buf0+buf1");
    expect_equal("phy_tx_en_o frame starts", 32'(starts), 32'h2);
    checks++;
    assert (min_gap >= IFG_CYCLES) else begin
      $display("FAIL phy_tx_en_o low gap: got 0x%0h, expected at least 0x%0h",
               min_gap, IFG_CYCLES);
      test_errors++;
    end
    end_test("ping-pong frames");

    @(negedge s_axi_aclk);
    phy_crs = 1'b1;
    len0 = $urandom_range(64, 1);
    load_frame(1'b0, len0);
    got_q.delete();
    write_bus(csr_byte_addr(REG_TX_STAT0), 32'h1);
    hold  = $urandom_range(100, 20);
    highs = 0;
    repeat (hold) begin
      @(negedge s_axi_aclk);
      if (phy_tx_en !== 1'b0) begin
        highs++;
      end
    end
    expect_equal("phy_tx_en_o under carrier", 32'(highs), 32'h0);
    phy_crs = 1'b0;
    wait_go_clear(REG_TX_STAT0);
    compare_frame("deferred buf0");
    end_test("carrier deferral");

    write_bus(csr_byte_addr(REG_INTR_EN), 32'h0);
    write_bus(csr_byte_addr(REG_INTR_STAT), 32'h1);
    read_expect("s_axi_rdata_o INTR_STAT", csr_byte_addr(REG_INTR_STAT), 32'h0);
    len1 = $urandom_range(64, 1);
    load_frame(1'b1, len1);
    got_q.delete();
    write_bus(csr_byte_addr(REG_TX_STAT1), 32'h1);
    wait_go_clear(REG_TX_STAT1);
    compare_frame("buf1");
    read_expect("s_axi_rdata_o INTR_STAT", csr_byte_addr(REG_INTR_STAT), 32'h1);
    expect_equal("eth_irq_o", 32'(eth_irq), 32'h0);
    write_bus(csr_byte_addr(REG_INTR_EN), 32'h1);
    @(negedge s_axi_aclk);
    expect_equal("eth_irq_o", 32'(eth_irq), 32'h1);
    write_bus(csr_byte_addr(REG_INTR_STAT), 32'h1);
    read_expect("s_axi_rdata_o INTR_STAT", csr_byte_addr(REG_INTR_STAT), 32'h0);
    expect_equal("eth_irq_o", 32'(eth_irq), 32'h0);
    end_test("interrupt");

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/eth_regs_pkg.sv
hw/eth_tx_pkg.sv
hw/axil_slave.sv
hw/mac_csr.sv
hw/tx_frame_ram.sv
hw/tx_engine.sv
hw/eth_mac_tx.sv
bench/tb_eth_mac_tx.sv

// File: Makefile
TOP = tb_eth_mac_tx

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "no pass line in sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
